// File: sources.f
design/rvExecPkg.sv
design/ctrlBus.sv
design/aluUnit.sv
design/regFile.sv
design/instDecoder.sv
design/execStage.sv
design/execCore.sv
verification/tbExecCore.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sources.f --top-module tbExecCore -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/VtbExecCore)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// File: verification/tbExecCore.sv
`default_nettype none

module tbExecCore import rvExecPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [31:0] due;
		logic resV;
		logic [regAddrW-1:0] rd;
		logic [xlen-1:0] data;
		logic redirV;
		logic [xlen-1:0] target;
		logic ill;
	} expect_t;

	logic rstn;
	logic rst;
	logic instValid;
	logic [xlen-1:0] inst;
	logic [xlen-1:0] pc;
	logic resValid;
	logic [regAddrW-1:0] resRd;
	logic [xlen-1:0] resData;
	logic redirectValid;
	logic [xlen-1:0] redirectPc;
	logic illegal;

	logic [xlen-1:0] shadow [0:31];
	expect_t pending [$];
	expect_t cur;
	int cyc;
	int errCount;
	int testErr;
	int issued;
	int tests;

	execCore dut0 (.*);

	initial begin
		rstn = 1'b0;
		forever #4 rstn = ~rstn;
	end

	// Outputs seen between edge N and N+1 belong to the instruction issued after edge N-2
	always begin
		@(posedge rstn);
		cyc = cyc + 1;
		#2;
		if (pending.size() != 0 && pending[0].due == cyc) begin
			cur = pending.pop_front();
		end else begin
			cur = '0;
		end
	end

	function automatic void logMismatch(string sig, logic [31:0] got, logic [31:0] want);
		errCount++;
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, sig, got, want);
	endfunction

	resValidOk: assert property (@(negedge rstn) disable iff (rst) resValid == cur.resV)
		else logMismatch("resValid", 32'(resValid), 32'(cur.resV));
	resRdOk: assert property (@(negedge rstn) disable iff (rst) cur.resV |-> resRd == cur.rd)
		else logMismatch("resRd", 32'(resRd), 32'(cur.rd));
	resDataOk: assert property (@(negedge rstn) disable iff (rst)
		cur.resV |-> resData == cur.data)
		else logMismatch("resData", resData, cur.data);
	redirectValidOk: assert property (@(negedge rstn) disable iff (rst)
		redirectValid == cur.redirV)
		else logMismatch("redirectValid", 32'(redirectValid), 32'(cur.redirV));
	redirectPcOk: assert property (@(negedge rstn) disable iff (rst)
		cur.redirV |-> redirectPc == cur.target)
		else logMismatch("redirectPc", redirectPc, cur.target);
	illegalOk: assert property (@(negedge rstn) disable iff (rst) illegal == cur.ill)
		else logMismatch("illegal", 32'(illegal), 32'(cur.ill));

	function automatic logic [31:0] sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] randPc();
		return $urandom() & 32'hFFFF_FFFC;
	endfunction

	// RV32I semantics by funct3, alt selects SUB and SRA
	function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic expect_t outcome(logic wr, logic [4:0] rd, logic [31:0] data,
		logic redir, logic [31:0] target, logic ill);
		expect_t e;
		e = '0;
		e.resV = wr && (rd != '0);
		e.rd = rd;
		e.data = data;
		e.redirV = redir;
		e.target = target;
		e.ill = ill;
		return e;
	endfunction

	task automatic issue(logic [31:0] word, logic [31:0] addr, expect_t e);
		@(posedge rstn);
		#1;
		instValid = 1'b1;
		inst = word;
		pc = addr;
		e.due = cyc + 2;
		pending.push_back(e);
		issued++;
	endtask

	task automatic idle();
		@(posedge rstn);
		#1;
		instValid = 1'b0;
	endtask

	task automatic finishTest(string name);
		int waited;
		waited = 0;
		idle();
		while (pending.size() != 0 && waited < 20) begin
			@(posedge rstn);
			waited++;
		end
		if (pending.size() != 0) begin
			$display("Timeout: %s still waits for %0d results", name, pending.size());
			errCount++;
			pending.delete();
		end
		@(negedge rstn);
		#1;
		tests++;
		$display("%s: done with %0d errors", name, errCount - testErr);
		testErr = errCount;
	endtask

	task automatic aluInst(logic useImm, logic [2:0] f3, logic alt, logic [4:0] rd,
		logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
		logic realAlt;
		logic [11:0] immF;
		logic [31:0] word;
		logic [31:0] b;
		logic [31:0] res;
		realAlt = alt && (f3 == 3'd5 || (f3 == 3'd0 && !useImm));
		immF = imm;
		if (f3 == 3'd1 || f3 == 3'd5) begin
			immF = {1'b0, realAlt, 5'b0, imm[4:0]};
		end
		b = useImm ? sext12(immF) : shadow[rs2];
		word = useImm ? {immF, rs1, f3, rd, opOpImm} :
			{1'b0, realAlt, 5'b0, rs2, rs1, f3, rd, opOp};
		res = aluRef(f3, realAlt, shadow[rs1], b);
		issue(word, randPc(), outcome(1'b1, rd, res, 1'b0, '0, 1'b0));
		if (rd != '0) begin
			shadow[rd] = res;
		end
	endtask

	task automatic upperInst(logic isAuipc, logic [4:0] rd, logic [19:0] imm);
		logic [31:0] addr;
		logic [31:0] res;
		addr = randPc();
		res = isAuipc ? addr + {imm, 12'b0} : {imm, 12'b0};
		issue({imm, rd, isAuipc ? opAuipc : opLui}, addr,
			outcome(1'b1, rd, res, 1'b0, '0, 1'b0));
		if (rd != '0) begin
			shadow[rd] = res;
		end
	endtask

	task automatic branchInst(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [31:0] rnd);
		logic [12:0] off;
		logic [31:0] addr;
		logic taken;
		off = {rnd[12:2], 2'b00};
		addr = randPc();
		taken = branchRef(f3, shadow[rs1], shadow[rs2]);
		issue({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch}, addr,
			outcome(1'b0, '0, '0, taken, addr + {{19{off[12]}}, off}, 1'b0));
	endtask

	task automatic jumpInst(logic isJalr, logic [4:0] rd, logic [4:0] rs1, logic [31:0] rnd);
		logic [20:0] off;
		logic [11:0] imm;
		logic [31:0] sum;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] target;
		addr = randPc();
		off = {rnd[20:2], 2'b00};
		word = {off[20], off[10:1], off[11], off[19:12], rd, opJal};
		target = addr + {{11{off[20]}}, off};
		if (isJalr) begin
			// Odd sums exercise the bit 0 clear, bit 1 stays 0 to keep targets aligned
			imm = rnd[11:0];
			imm[0] = shadow[rs1][0] ^ rnd[31];
			sum = shadow[rs1] + sext12(imm);
			if (sum[1]) begin
				imm[1] = ~imm[1];
				sum = shadow[rs1] + sext12(imm);
			end
			word = {imm, rs1, 3'b000, rd, opJalr};
			target = {sum[31:1], 1'b0};
		end
		issue(word, addr, outcome(1'b1, rd, addr + 32'd4, 1'b1, target, 1'b0));
		if (rd != '0) begin
			shadow[rd] = addr + 32'd4;
		end
	endtask

	task automatic illegalInst(logic [31:0] word);
		issue(word, randPc(), outcome(1'b0, '0, '0, 1'b0, '0, 1'b1));
	endtask

	initial begin
		logic [31:0] rnd;
		void'($urandom(2));
		rst = 1'b1;
		instValid = 1'b0;
		inst = '0;
		pc = '0;
		cur = '0;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		repeat (8) @(posedge rstn);
		#1;
		rst = 1'b0;
		repeat (4) idle();
		finishTest("reset");

		// Upper immediates seed x1 to x7
		for (int i = 1; i < 8; i++) begin
			upperInst(1'b0, 5'(i), 20'($urandom()));
		end
		for (int i = 0; i < 8; i++) begin
			upperInst(1'b1, 5'(i), 20'($urandom()));
		end
		finishTest("lui/auipc");

		// Small register range gives back-to-back dependencies and x0 writes
		for (int i = 0; i < 80; i++) begin
			rnd = $urandom();
			aluInst(rnd[0], rnd[3:1], rnd[4], {2'b00, rnd[7:5]}, {2'b00, rnd[10:8]},
				{2'b00, rnd[13:11]}, rnd[25:14]);
		end
		finishTest("alu");

		// x1 negative, x2 small positive
		aluInst(1'b1, 3'd0, 1'b0, 5'd1, 5'd0, 5'd0, 12'hFFB);
		aluInst(1'b1, 3'd0, 1'b0, 5'd2, 5'd0, 5'd0, 12'h007);
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				branchInst(3'(f), 5'd1, 5'd1, $urandom());
				branchInst(3'(f), 5'd1, 5'd2, $urandom());
				branchInst(3'(f), 5'd2, 5'd1, $urandom());
			end
		end
		finishTest("branch");

		for (int i = 0; i < 16; i++) begin
			rnd = $urandom();
			jumpInst(i[0], {2'b00, rnd[2:0]}, {2'b00, rnd[5:3]}, $urandom());
		end
		finishTest("jump");

		rnd = $urandom();
		illegalInst({rnd[31:15], 3'b010, 5'd3, 7'b0000011});
		illegalInst({rnd[31:15], 3'b010, rnd[11:7], 7'b0100011});
		illegalInst(32'h0000_0000);
		// Copy x3 to x4 to show the load left x3 alone
		aluInst(1'b1, 3'd0, 1'b0, 5'd4, 5'd3, 5'd0, 12'd0);
		finishTest("illegal");

		$display("%0d tests, %0d instructions, %0d errors", tests, issued, errCount);
		if (errCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/execCore.sv
`default_nettype none

module execCore import rvExecPkg::*; (
	input logic rstn,
	input logic rst,
	input logic instValid,
	input logic [xlen-1:0] inst,
	input logic [xlen-1:0] pc,
	output logic resValid,
	output logic [regAddrW-1:0] resRd,
	output logic [xlen-1:0] resData,
	output logic redirectValid,
	output logic [xlen-1:0] redirectPc,
	output logic illegal
);

	logic [regAddrW-1:0] rdAddrA;
	logic [regAddrW-1:0] rdAddrB;
	logic [xlen-1:0] rdDataA;
	logic [xlen-1:0] rdDataB;
	logic wrEn;
	logic [regAddrW-1:0] wrAddr;
	logic [xlen-1:0] wrData;

	ctrlBus bus0 ();

	instDecoder dec0 (
		.rstn(rstn),
		.rst(rst),
		.instValid(instValid),
		.inst(inst),
		.pc(pc),
		.bus(bus0.dec),
		.illegal(illegal)
	);

	execStage exe0 (
		.rstn(rstn),
		.rst(rst),
		.bus(bus0.exe),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.resValid(resValid),
		.resRd(resRd),
		.resData(resData),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc)
	);

	regFile rf0 (
		.rstn(rstn),
		.rst(rst),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

endmodule

`default_nettype wire

// File: design/execStage.sv
`default_nettype none

module execStage import rvExecPkg::*; (
	input logic rstn,
	input logic rst,
	ctrlBus.exe bus,
	output logic [regAddrW-1:0] rdAddrA,
	output logic [regAddrW-1:0] rdAddrB,
	input logic [xlen-1:0] rdDataA,
	input logic [xlen-1:0] rdDataB,
	output logic wrEn,
	output logic [regAddrW-1:0] wrAddr,
	output logic [xlen-1:0] wrData,
	output logic resValid,
	output logic [regAddrW-1:0] resRd,
	output logic [xlen-1:0] resData,
	output logic redirectValid,
	output logic [xlen-1:0] redirectPc
);

	logic [xlen-1:0] opB;
	logic [xlen-1:0] aluRes;
	logic taken;
	logic [xlen-1:0] linkAddr;
	logic [xlen-1:0] pcTarget;
	logic [xlen-1:0] resNext;
	logic [xlen-1:0] targetNext;
	logic redirNext;

	assign rdAddrA = bus.rs1;
	assign rdAddrB = bus.rs2;
	assign opB = bus.useImm ? bus.imm : rdDataB;

	aluUnit alu0 (
		.op(bus.aluOp),
		.a(rdDataA),
		.b(opB),
		.result(aluRes),
		.cond(taken)
	);

	assign linkAddr = bus.pc + 32'd4;
	assign pcTarget = bus.pc + bus.imm;

	always_comb begin
		resNext = aluRes;
		targetNext = pcTarget;
		redirNext = 1'b0;
		case (bus.kind)
			kindLui: resNext = bus.imm;
			kindAuipc: resNext = pcTarget;
			kindJal: begin
				resNext = linkAddr;
				redirNext = 1'b1;
			end
			kindJalr: begin
				// ALU already holds rs1 + imm
				resNext = linkAddr;
				targetNext = {aluRes[xlen-1:1], 1'b0};
				redirNext = 1'b1;
			end
			kindBranch: redirNext = taken;
			default: ;
		endcase
	end

	// Write lands on this edge so the next instruction sees it
	assign wrEn = bus.valid && bus.regWrite && (bus.rd != '0);
	assign wrAddr = bus.rd;
	assign wrData = resNext;

	always_ff @(posedge rstn) begin
		if (rst) begin
			resValid <= 1'b0;
			redirectValid <= 1'b0;
		end else begin
			resValid <= wrEn;
			redirectValid <= bus.valid && redirNext;
		end
	end

	always_ff @(posedge rstn) begin
		resRd <= bus.rd;
		resData <= resNext;
		redirectPc <= targetNext;
	end

	targetAligned: assert property (@(posedge rstn) disable iff (rst)
		redirectValid |-> (redirectPc[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: design/instDecoder.sv
`default_nettype none

module instDecoder import rvExecPkg::*; (
	input logic rstn,
	input logic rst,
	input logic instValid,
	input instWord_u inst,
	input logic [xlen-1:0] pc,
	ctrlBus.dec bus,
	output logic illegal
);

	logic [xlen-1:0] immI;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;
	logic legal;
	instKind_e kindNext;
	aluOp_e opNext;
	logic useImmNext;
	logic writeNext;
	logic [xlen-1:0] immNext;
	logic illegalQ;

	assign immI = {{20{inst.iType.imm[11]}}, inst.iType.imm};
	assign immB = {{20{inst.bType.imm12}}, inst.bType.imm11, inst.bType.imm10to5,
		inst.bType.imm4to1, 1'b0};
	assign immU = {inst.uType.imm, 12'b0};
	assign immJ = {{12{inst.jType.imm20}}, inst.jType.imm19to12, inst.jType.imm11,
		inst.jType.imm10to1, 1'b0};

	always_comb begin
		legal = 1'b1;
		kindNext = kindAlu;
		opNext = aluAdd;
		useImmNext = 1'b0;
		writeNext = 1'b1;
		immNext = '0;
		case (inst.rType.opcode)
			opOp: begin
				case ({inst.rType.funct7, inst.rType.funct3})
					{7'b0000000, 3'b000}: opNext = aluAdd;
					{7'b0100000, 3'b000}: opNext = aluSub;
					{7'b0000000, 3'b001}: opNext = aluSll;
					{7'b0000000, 3'b010}: opNext = aluSlt;
					{7'b0000000, 3'b011}: opNext = aluSltu;
					{7'b0000000, 3'b100}: opNext = aluXor;
					{7'b0000000, 3'b101}: opNext = aluSrl;
					{7'b0100000, 3'b101}: opNext = aluSra;
					{7'b0000000, 3'b110}: opNext = aluOr;
					{7'b0000000, 3'b111}: opNext = aluAnd;
					default: legal = 1'b0;
				endcase
			end
			opOpImm: begin
				useImmNext = 1'b1;
				immNext = immI;
				case (inst.iType.funct3)
					3'b000: opNext = aluAdd;
					3'b010: opNext = aluSlt;
					3'b011: opNext = aluSltu;
					3'b100: opNext = aluXor;
					3'b110: opNext = aluOr;
					3'b111: opNext = aluAnd;
					// Shift immediates reuse funct7 from the R view
					3'b001: begin
						opNext = aluSll;
						legal = (inst.rType.funct7 == 7'b0000000);
					end
					default: begin
						opNext = inst.rType.funct7[5] ? aluSra : aluSrl;
						legal = (inst.rType.funct7 == 7'b0000000) ||
							(inst.rType.funct7 == 7'b0100000);
					end
				endcase
			end
			opLui: begin
				kindNext = kindLui;
				immNext = immU;
			end
			opAuipc: begin
				kindNext = kindAuipc;
				immNext = immU;
			end
			opJal: begin
				kindNext = kindJal;
				immNext = immJ;
			end
			opJalr: begin
				kindNext = kindJalr;
				useImmNext = 1'b1;
				immNext = immI;
				legal = (inst.iType.funct3 == 3'b000);
			end
			opBranch: begin
				kindNext = kindBranch;
				writeNext = 1'b0;
				immNext = immB;
				case (inst.bType.funct3)
					3'b000: opNext = aluEq;
					3'b001: opNext = aluNe;
					3'b100: opNext = aluLt;
					3'b101: opNext = aluGe;
					3'b110: opNext = aluLtu;
					3'b111: opNext = aluGeu;
					default: legal = 1'b0;
				endcase
			end
			// Loads, stores, fence and system land here
			default: legal = 1'b0;
		endcase
	end

	always_ff @(posedge rstn) begin
		if (rst) begin
			bus.valid <= 1'b0;
			illegalQ <= 1'b0;
			illegal <= 1'b0;
		end else begin
			bus.valid <= instValid && legal;
			// Extra stage lines illegal up with the execute strobes
			illegalQ <= instValid && !legal;
			illegal <= illegalQ;
		end
	end

	always_ff @(posedge rstn) begin
		bus.kind <= kindNext;
		bus.aluOp <= opNext;
		bus.useImm <= useImmNext;
		bus.regWrite <= writeNext;
		bus.rd <= inst.rType.rd;
		bus.rs1 <= inst.rType.rs1;
		bus.rs2 <= inst.rType.rs2;
		bus.imm <= immNext;
		bus.pc <= pc;
	end

	ctrlKnown: assert property (@(posedge rstn) disable iff (rst)
		bus.valid |-> !$isunknown({bus.kind, bus.aluOp, bus.rd, bus.rs1, bus.rs2,
			bus.imm, bus.pc}));

endmodule

`default_nettype wire

// File: design/regFile.sv
`default_nettype none

module regFile import rvExecPkg::*; (
	input logic rstn,
	input logic rst,
	input logic [regAddrW-1:0] rdAddrA,
	input logic [regAddrW-1:0] rdAddrB,
	output logic [xlen-1:0] rdDataA,
	output logic [xlen-1:0] rdDataB,
	input logic wrEn,
	input logic [regAddrW-1:0] wrAddr,
	input logic [xlen-1:0] wrData
);

	// x0 has no storage
	logic [xlen-1:0] regs [1:(1 << regAddrW)-1];

	always_ff @(posedge rstn) begin
		if (rst) begin
			for (int i = 1; i < (1 << regAddrW); i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: design/aluUnit.sv
`default_nettype none

module aluUnit import rvExecPkg::*; (
	input aluOp_e op,
	input logic [xlen-1:0] a,
	input logic [xlen-1:0] b,
	output logic [xlen-1:0] result,
	output logic cond
);

	logic [4:0] shamt;
	logic lessS;
	logic lessU;

	assign shamt = b[4:0];
	assign lessS = $signed(a) < $signed(b);
	assign lessU = a < b;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = $signed(a) >>> shamt;
			aluSlt: result = {{(xlen-1){1'b0}}, lessS};
			aluSltu: result = {{(xlen-1){1'b0}}, lessU};
			// Compare codes produce only cond
			default: result = '0;
		endcase
	end

	always_comb begin
		case (op)
			aluEq: cond = (a == b);
			aluNe: cond = (a != b);
			aluLt: cond = lessS;
			aluGe: cond = !lessS;
			aluLtu: cond = lessU;
			aluGeu: cond = !lessU;
			default: cond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/ctrlBus.sv
`default_nettype none

interface ctrlBus import rvExecPkg::*; ();

	logic valid;
	instKind_e kind;
	aluOp_e aluOp;
	logic useImm;
	logic regWrite;
	logic [regAddrW-1:0] rd;
	logic [regAddrW-1:0] rs1;
	logic [regAddrW-1:0] rs2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] pc;

	modport dec (
		output valid, kind, aluOp, useImm, regWrite,
		output rd, rs1, rs2, imm, pc
	);

	modport exe (
		input valid, kind, aluOp, useImm, regWrite,
		input rd, rs1, rs2, imm, pc
	);

endinterface

`default_nettype wire

// File: design/rvExecPkg.sv
`default_nettype none

package rvExecPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// Major opcodes handled by the execute path
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;

	// Last six codes are branch compares
	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr,
		aluXor, aluSll, aluSrl, aluSra,
		aluSlt, aluSltu, aluEq, aluNe,
		aluLt, aluGe, aluLtu, aluGeu
	} aluOp_e;

	typedef enum logic [2:0] {
		kindAlu, kindLui, kindAuipc, kindJal, kindJalr, kindBranch
	} instKind_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iFmt_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFmt_t;

	// Branch offset bits are scattered
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4to1;
		logic imm11;
		logic [6:0] opcode;
	} bFmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		logic [6:0] opcode;
	} uFmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} jFmt_t;

	typedef union packed {
		rFmt_t rType;
		iFmt_t iType;
		sFmt_t sType;
		bFmt_t bType;
		uFmt_t uType;
		jFmt_t jType;
	} instWord_u;

endpackage

`default_nettype wire
